// File: compile.f
src/noc_pkg.sv
src/flit_fifo.sv
src/vc_buffer.sv
src/flit_packetizer.sv
src/flit_sink.sv
src/vc_channel_top.sv
tb/tb_clock_gen.sv
tb/vc_channel_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the VC channel testbench with Verilator.
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f compile.f --top-module vc_channel_tb \
  || { echo "Build failed"; exit 1; }
./obj_dir/Vvc_channel_tb > sim.log 2>&1
cat sim.log
grep -q "Something failed" sim.log && { echo "FAIL"; exit 1; } || true
grep -q "Everything OK" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: src/flit_fifo.sv
// Flit FIFO
`default_nettype none

module flit_fifo (
  input  logic             clk,
  input  logic             arst,
  input  logic             write_i,
  input  logic             read_i,
  input  noc_pkg::u_flit_t data_i,
  output noc_pkg::u_flit_t data_o,
  output logic             full_o,
  output logic             empty_o,
  output logic             error_o
);

  logic [noc_pkg::FlitWidth-1:0] mem_q [noc_pkg::FlitBuff]; // Flit storage.
  noc_pkg::ptr_t wr_ptr_q;
  noc_pkg::ptr_t rd_ptr_q;
  noc_pkg::ptr_t wr_ptr_nx;
  noc_pkg::ptr_t rd_ptr_nx;
  noc_pkg::cnt_t count_q;
  logic          do_write;
  logic          do_read;

  always_comb begin
    full_o   = (count_q == noc_pkg::cnt_t'(noc_pkg::FlitBuff)); // All slots taken.
    empty_o  = (count_q == '0);
    do_write = write_i && !full_o;                               // Drop on overflow.
    do_read  = read_i && !empty_o;
    error_o  = (write_i && full_o) || (read_i && empty_o);       // Misuse by the caller.
    wr_ptr_nx = (wr_ptr_q == noc_pkg::ptr_t'(noc_pkg::FlitBuff - 1)) ? '0 : wr_ptr_q + 1'b1;
    rd_ptr_nx = (rd_ptr_q == noc_pkg::ptr_t'(noc_pkg::FlitBuff - 1)) ? '0 : rd_ptr_q + 1'b1;
    data_o   = noc_pkg::u_flit_t'(mem_q[rd_ptr_q]);             // Oldest entry.
  end

  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_write) wr_ptr_q <= wr_ptr_nx;
      if (do_read)  rd_ptr_q <= rd_ptr_nx;
      case ({do_write, do_read})
        2'b10:   count_q <= count_q + 1'b1;                     // Push only.
        2'b01:   count_q <= count_q - 1'b1;                     // Pop only.
        default: count_q <= count_q;                            // Both or neither.
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_write) mem_q[wr_ptr_q] <= data_i;
  end

  fifo_no_error: assert property (
    @(posedge clk) disable iff (arst) !error_o
  ) else $error("flit_fifo: write while full or read while empty");

endmodule

`default_nettype wire

// File: src/flit_packetizer.sv
// Flit packetizer
`default_nettype none

module flit_packetizer (
  input  logic                           clk,
  input  logic                           arst,
  input  logic                           req_valid_i,
  input  noc_pkg::s_pkt_req_t            req_i,
  output logic                           req_ready_o,
  input  logic                           word_valid_i,
  input  logic [noc_pkg::WordWidth-1:0]  word_i,
  output logic                           word_ready_o,
  output noc_pkg::u_flit_t               flit_o,
  output logic                           flit_valid_o,
  input  logic                           flit_ready_i
);

  typedef enum logic [1:0] {
    IDLE,                                                      // Waiting for request.
    HEAD,                                                      // Head flit offered.
    PAYLOAD                                                    // Words streaming.
  } state_t;

  state_t                state_q;
  noc_pkg::u_flit_t      flit_q;                               // Output flit stage.
  logic                  flit_valid_q;
  noc_pkg::size_t        remain_q;                             // Words still to take.
  noc_pkg::s_flit_head_t head_w;
  noc_pkg::s_flit_data_t data_w;
  logic                  req_xfer;
  logic                  word_xfer;
  logic                  flit_xfer;

  always_comb begin
    req_ready_o  = (state_q == IDLE);
    // Take a word when the stage is free or draining this cycle.
    word_ready_o = (state_q != IDLE) && (remain_q != '0) && (!flit_valid_q || flit_ready_i);
    req_xfer     = req_valid_i && req_ready_o;
    word_xfer    = word_valid_i && word_ready_o;
    flit_xfer    = flit_valid_q && flit_ready_i;
    head_w.type_f   = noc_pkg::HEAD_FLIT;
    head_w.dest     = req_i.dest;
    head_w.pkt_size = req_i.pkt_size;
    head_w.tag      = req_i.tag;
    data_w.type_f   = (remain_q == noc_pkg::size_t'(1)) ? noc_pkg::TAIL_FLIT
                                                        : noc_pkg::BODY_FLIT; // Last word.
    data_w.payload  = word_i;
    flit_o       = flit_q;
    flit_valid_o = flit_valid_q;
  end

  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      state_q      <= IDLE;
      flit_valid_q <= 1'b0;
      remain_q     <= '0;
    end else if (req_xfer) begin
      state_q      <= HEAD;
      flit_valid_q <= 1'b1;                                    // Head next cycle.
      remain_q     <= req_i.pkt_size;
    end else if (word_xfer) begin
      state_q      <= PAYLOAD;
      flit_valid_q <= 1'b1;                                    // Stage refilled.
      remain_q     <= remain_q - 1'b1;
    end else if (flit_xfer) begin
      flit_valid_q <= 1'b0;
      state_q      <= (remain_q == '0) ? IDLE : PAYLOAD;       // Done after last flit.
    end
  end

  always_ff @(posedge clk) begin
    if (req_xfer) begin
      flit_q.head <= head_w;
    end else if (word_xfer) begin
      flit_q.data <= data_w;
    end
  end

  flit_held_stable: assert property (
    @(posedge clk) disable iff (arst)
    (flit_valid_o && !flit_ready_i) |=> (flit_valid_o && $stable(flit_o))
  ) else $error("flit_packetizer: flit changed while stalled");

endmodule

`default_nettype wire

// File: src/flit_sink.sv
// Flit sink
`default_nettype none

module flit_sink (
  input  logic                clk,
  input  logic                arst,
  input  noc_pkg::u_flit_t    flit_i,
  input  logic                flit_valid_i,
  output logic                flit_ready_o,
  input  logic                stall_i,
  output logic                pkt_done_o,
  output noc_pkg::s_pkt_sum_t pkt_sum_o
);

  logic                xfer;
  logic                is_head;
  logic                is_tail;
  logic                pkt_end;                                // Packet closes now.
  logic                in_pkt_q;
  logic                done_q;
  noc_pkg::s_pkt_sum_t acc_q;                                  // Running summary.
  noc_pkg::s_pkt_sum_t acc_nx;
  noc_pkg::s_pkt_sum_t sum_q;                                  // Last finished packet.

  always_comb begin
    flit_ready_o = !stall_i;                                   // External back-pressure.
    xfer         = flit_valid_i && flit_ready_o;
    is_head      = (flit_i.head.type_f == noc_pkg::HEAD_FLIT);
    is_tail      = (flit_i.data.type_f == noc_pkg::TAIL_FLIT);
    pkt_end      = xfer && (is_tail || (is_head && (flit_i.head.pkt_size == '0)));
    acc_nx          = acc_q;
    acc_nx.word_cnt = acc_q.word_cnt + 1'b1;
    acc_nx.checksum = acc_q.checksum + flit_i.data.payload;    // Wraps at 32 bits.
    if (is_head) begin
      acc_nx.dest     = flit_i.head.dest;
      acc_nx.pkt_size = flit_i.head.pkt_size;
      acc_nx.tag      = flit_i.head.tag;
      acc_nx.word_cnt = '0;
      acc_nx.checksum = '0;
    end
    pkt_done_o = done_q;
    pkt_sum_o  = sum_q;
  end

  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      in_pkt_q <= 1'b0;
      done_q   <= 1'b0;
    end else begin
      done_q <= pkt_end;                                       // One-cycle pulse.
      if (xfer && is_head) begin
        in_pkt_q <= (flit_i.head.pkt_size != '0);
      end else if (xfer && is_tail) begin
        in_pkt_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (xfer)    acc_q <= acc_nx;
    if (pkt_end) sum_q <= acc_nx;
  end

  payload_inside_packet: assert property (
    @(posedge clk) disable iff (arst) (xfer && !is_head) |-> in_pkt_q
  ) else $error("flit_sink: body or tail flit without a head");

endmodule

`default_nettype wire

// File: src/noc_pkg.sv
// NoC channel shared types
`default_nettype none

package noc_pkg;

  localparam int FlitWidth  = 34;                     // Type plus content bits.
  localparam int TypeWidth  = 2;                      // Flit type field.
  localparam int WordWidth  = 32;                     // Payload word.
  localparam int DestWidth  = 4;                      // Destination id.
  localparam int TagWidth   = 24;                     // Packet tag.
  localparam int FlitBuff   = 4;                      // FIFO depth in flits.
  localparam int MaxPktSize = 15;                     // Largest payload count.
  localparam int SizeWidth  = $clog2(MaxPktSize + 1); // Holds 0 to MaxPktSize.
  localparam int PtrWidth   = $clog2(FlitBuff);       // FIFO pointer.
  localparam int CntWidth   = $clog2(FlitBuff + 1);   // FIFO fill level.

  typedef logic [SizeWidth-1:0] size_t;
  typedef logic [PtrWidth-1:0]  ptr_t;
  typedef logic [CntWidth-1:0]  cnt_t;

  typedef enum logic [TypeWidth-1:0] {
    HEAD_FLIT = 2'd0,                                 // Opens a packet.
    BODY_FLIT = 2'd1,                                 // Middle payload word.
    TAIL_FLIT = 2'd2                                  // Last payload word.
  } flit_type_t;

  // Head view of a flit word.
  typedef struct packed {
    flit_type_t            type_f;
    logic [DestWidth-1:0]  dest;
    size_t                 pkt_size;                  // Words that follow.
    logic [TagWidth-1:0]   tag;
  } s_flit_head_t;

  // Data view for body and tail.
  typedef struct packed {
    flit_type_t            type_f;
    logic [WordWidth-1:0]  payload;
  } s_flit_data_t;

  typedef union packed {
    s_flit_head_t head;
    s_flit_data_t data;
  } u_flit_t;

  typedef struct packed {
    logic [DestWidth-1:0]  dest;
    size_t                 pkt_size;
    logic [TagWidth-1:0]   tag;
  } s_pkt_req_t;

  typedef struct packed {
    logic [DestWidth-1:0]  dest;
    size_t                 pkt_size;
    logic [TagWidth-1:0]   tag;
    size_t                 word_cnt;                  // Words received.
    logic [WordWidth-1:0]  checksum;                  // Wrapping word sum.
  } s_pkt_sum_t;

endpackage

`default_nettype wire

// File: src/vc_buffer.sv
// Virtual channel buffer
`default_nettype none

module vc_buffer (
  input  logic             clk,
  input  logic             arst,
  input  noc_pkg::u_flit_t flit_i,
  input  logic             valid_i,
  output logic             ready_o,
  output noc_pkg::u_flit_t flit_o,
  output logic             valid_o,
  input  logic             ready_i,
  output logic             full_o,
  output logic             empty_o
);

  logic write_flit;
  logic read_flit;
  logic is_head;
  logic is_tail;
  logic locked_q;                                              // Packet in progress.

  flit_fifo u_vc_fifo (
    .clk     (clk),
    .arst    (arst),
    .write_i (write_flit),
    .read_i  (read_flit),
    .data_i  (flit_i),
    .data_o  (flit_o),
    .full_o  (full_o),
    .empty_o (empty_o),
    .error_o ()
  );

  always_comb begin
    is_head    = (flit_i.head.type_f == noc_pkg::HEAD_FLIT);
    is_tail    = (flit_i.data.type_f == noc_pkg::TAIL_FLIT);
    ready_o    = !full_o && !(is_head && locked_q);            // New head waits for tail.
    write_flit = valid_i && ready_o;
    valid_o    = !empty_o;
    read_flit  = valid_o && ready_i;
  end

  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      locked_q <= 1'b0;
    end else if (write_flit) begin
      if (is_head && (flit_i.head.pkt_size != '0)) begin
        locked_q <= 1'b1;                                      // Multi-flit packet opens.
      end else if (is_tail) begin
        locked_q <= 1'b0;                                      // Packet closes.
      end
    end
  end

  no_payload_while_unlocked: assert property (
    @(posedge clk) disable iff (arst) (write_flit && !is_head) |-> locked_q
  ) else $error("vc_buffer: body or tail written outside a packet");

endmodule

`default_nettype wire

// File: src/vc_channel_top.sv
// Virtual channel top level
`default_nettype none

module vc_channel_top (
  input  logic                           clk,
  input  logic                           arst,
  input  logic                           req_valid_i,
  input  noc_pkg::s_pkt_req_t            req_i,
  output logic                           req_ready_o,
  input  logic                           word_valid_i,
  input  logic [noc_pkg::WordWidth-1:0]  word_i,
  output logic                           word_ready_o,
  input  logic                           stall_i,
  output logic                           pkt_done_o,
  output noc_pkg::s_pkt_sum_t            pkt_sum_o,
  output logic                           full_o,
  output logic                           empty_o
);

  noc_pkg::u_flit_t pk_flit;                                   // Packetizer to buffer.
  logic             pk_valid;
  logic             pk_ready;
  noc_pkg::u_flit_t bf_flit;                                   // Buffer to sink.
  logic             bf_valid;
  logic             sk_ready;

  flit_packetizer u_packetizer (
    .clk          (clk),
    .arst         (arst),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i),
    .req_ready_o  (req_ready_o),
    .word_valid_i (word_valid_i),
    .word_i       (word_i),
    .word_ready_o (word_ready_o),
    .flit_o       (pk_flit),
    .flit_valid_o (pk_valid),
    .flit_ready_i (pk_ready)
  );

  vc_buffer u_vc_buffer (
    .clk     (clk),
    .arst    (arst),
    .flit_i  (pk_flit),
    .valid_i (pk_valid),
    .ready_o (pk_ready),
    .flit_o  (bf_flit),
    .valid_o (bf_valid),
    .ready_i (sk_ready),
    .full_o  (full_o),
    .empty_o (empty_o)
  );

  flit_sink u_sink (
    .clk          (clk),
    .arst         (arst),
    .flit_i       (bf_flit),
    .flit_valid_i (bf_valid),
    .flit_ready_o (sk_ready),
    .stall_i      (stall_i),
    .pkt_done_o   (pkt_done_o),
    .pkt_sum_o    (pkt_sum_o)
  );

endmodule

`default_nettype wire

// File: tb/tb_clock_gen.sv
// Testbench clock and reset
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic arst_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;                         // Period of 10.
  end

  initial begin
    arst_o = 1'b1;
    repeat (3) @(posedge clk_o);                       // Three rising edges in reset.
    @(negedge clk_o);                                  // Release away from the rising edge.
    arst_o = 1'b0;
  end

endmodule

`default_nettype wire

// File: tb/vc_channel_tb.sv
// VC channel testbench
`default_nettype none

module vc_channel_tb;

  localparam int NumRand = 20;                         // Random packets.
  localparam int NumPkts = NumRand + 3;                // Plus the directed ones.
  localparam int SumBits = $bits(noc_pkg::s_pkt_sum_t);

  logic                          clk;
  logic                          arst;
  logic                          arst_q;               // Reset seen at the last edge.
  logic                          req_valid_i;
  noc_pkg::s_pkt_req_t           req_i;
  logic                          req_ready_o;
  logic                          word_valid_i;
  logic [noc_pkg::WordWidth-1:0] word_i;
  logic                          word_ready_o;
  logic                          stall_i;
  logic                          pkt_done_o;
  noc_pkg::s_pkt_sum_t           pkt_sum_o;
  logic                          full_o;
  logic                          empty_o;
  logic [31:0]                   rng_q;                // LCG state.
  logic                          saw_full;             // FIFO reached full.
  noc_pkg::s_pkt_sum_t           exp_mem [32];         // Expected summaries in send order.
  logic [4:0]                    exp_wr;
  logic [4:0]                    exp_rd;
  logic [31:0]                   r;
  logic [31:0]                   t;
  int                            k;

  tb_clock_gen u_clk_gen (.clk_o(clk), .arst_o(arst));

  vc_channel_top dut (
    .clk          (clk),
    .arst         (arst),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i),
    .req_ready_o  (req_ready_o),
    .word_valid_i (word_valid_i),
    .word_i       (word_i),
    .word_ready_o (word_ready_o),
    .stall_i      (stall_i),
    .pkt_done_o   (pkt_done_o),
    .pkt_sum_o    (pkt_sum_o),
    .full_o       (full_o),
    .empty_o      (empty_o)
  );

  function automatic logic [31:0] next_rand();
    rng_q = rng_q * 32'd1103515245 + 32'd12345;         // Classic 32-bit LCG.
    return rng_q;
  endfunction

  task automatic report_mismatch(input string name, input logic [SumBits-1:0] expected,
                                 input logic [SumBits-1:0] actual);
    $display("Error at time %0t: %s expected %0h got %0h", $time, name, expected, actual);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic report_failure(input string what);
    $display("%s at time %0t", what, $time);
    $display("Something failed");
    $fatal(1);
  endtask

  // Queues the expected summary and drives request and words until all are taken.
  task automatic send_packet(input logic [noc_pkg::DestWidth-1:0] dest,
                             input noc_pkg::size_t size,
                             input logic [noc_pkg::TagWidth-1:0] tag,
                             input int hold, input logic [7:0] stall_lvl);
    logic [noc_pkg::WordWidth-1:0] words [noc_pkg::MaxPktSize + 1];
    logic [noc_pkg::WordWidth-1:0] sum;
    noc_pkg::s_pkt_sum_t           exp;
    noc_pkg::size_t                i;
    noc_pkg::size_t                n;                  // Words accepted so far.
    logic [31:0]                   rs;
    logic                          req_done;
    int                            cyc;
    sum = '0;
    for (i = '0; i < size; i++) begin
      words[i] = next_rand();
      sum      = sum + words[i];                       // Wraps at 32 bits.
    end
    exp.dest         = dest;
    exp.pkt_size     = size;
    exp.tag          = tag;
    exp.word_cnt     = size;
    exp.checksum     = sum;
    exp_mem[exp_wr]  = exp;
    exp_wr++;
    req_done = 1'b0;
    n        = '0;
    cyc      = 0;
    while (!req_done || (n < size)) begin
      @(negedge clk);
      rs           = next_rand();
      stall_i      = (cyc < hold) || (rs[23:16] < stall_lvl);
      req_valid_i  = !req_done;
      req_i        = '{dest: dest, pkt_size: size, tag: tag};
      word_valid_i = req_done && (n < size);           // Held until taken.
      word_i       = (n < size) ? words[n] : '0;
      if (req_valid_i && req_ready_o) begin
        req_done = 1'b1;                               // Transfers at the next rise.
      end else if (word_valid_i && word_ready_o) begin
        n++;
      end
      cyc++;
    end
  endtask

  task automatic drain_channel();
    @(negedge clk);
    req_valid_i  = 1'b0;
    word_valid_i = 1'b0;
    stall_i      = 1'b0;
    while (exp_rd != exp_wr) @(negedge clk);           // Until every summary is seen.
  endtask

  always @(posedge clk) arst_q <= arst;

  always @(posedge clk or posedge arst) begin
    if (arst) begin
      exp_rd   <= '0;
      saw_full <= 1'b0;
    end else begin
      if (pkt_done_o) exp_rd <= exp_rd + 1'b1;         // Next expected summary.
      if (full_o)     saw_full <= 1'b1;
    end
  end

  reset_no_done: assert property (@(posedge clk) (arst || arst_q) |-> !pkt_done_o)
    else report_mismatch("pkt_done_o", SumBits'(1'b0), SumBits'($sampled(pkt_done_o)));
  reset_no_word: assert property (@(posedge clk) (arst || arst_q) |-> !word_ready_o)
    else report_mismatch("word_ready_o", SumBits'(1'b0), SumBits'($sampled(word_ready_o)));
  reset_req_rdy: assert property (@(posedge clk) (arst || arst_q) |-> req_ready_o)
    else report_mismatch("req_ready_o", SumBits'(1'b1), SumBits'($sampled(req_ready_o)));
  reset_empty: assert property (@(posedge clk) (arst || arst_q) |-> empty_o)
    else report_mismatch("empty_o", SumBits'(1'b1), SumBits'($sampled(empty_o)));
  reset_not_full: assert property (@(posedge clk) (arst || arst_q) |-> !full_o)
    else report_mismatch("full_o", SumBits'(1'b0), SumBits'($sampled(full_o)));

  done_expected: assert property (@(posedge clk) disable iff (arst)
    pkt_done_o |-> (exp_rd < exp_wr))
    else report_failure("pkt_done_o pulsed with no packet outstanding");

  summary_match: assert property (@(posedge clk) disable iff (arst)
    pkt_done_o |-> (pkt_sum_o == exp_mem[exp_rd]))
    else report_mismatch("pkt_sum_o", $sampled(exp_mem[exp_rd]), $sampled(pkt_sum_o));

  full_blocks_words: assert property (@(posedge clk) disable iff (arst)
    full_o |-> !word_ready_o)
    else report_mismatch("word_ready_o", SumBits'(1'b0), SumBits'($sampled(word_ready_o)));

  initial begin
    repeat (40 * NumPkts) @(posedge clk);              // 40 cycles per packet.
    report_failure("Timeout, the channel did not deliver every packet in time");
  end

  initial begin
    req_valid_i  = 1'b0;
    req_i        = '0;
    word_valid_i = 1'b0;
    word_i       = '0;
    stall_i      = 1'b0;
    exp_wr       = '0;
    rng_q        = 32'd37139;
    @(negedge arst);
    @(negedge clk);
    send_packet(4'h5, 4'd0, 24'h0badc0, 0, 8'd0);      // Head only.
    drain_channel();
    send_packet(4'ha, 4'd15, 24'h123456, 0, 8'd0);     // Longest packet without stall.
    drain_channel();
    send_packet(4'h3, 4'd15, 24'h00beef, 12, 8'd0);    // Sink stalled at first.
    drain_channel();
    fifo_filled: assert (saw_full)
      else report_failure("full_o never rose while the sink was stalled");
    for (k = 0; k < NumRand; k++) begin
      r = next_rand();
      t = next_rand();
      send_packet(r[31:28], r[27:24], t[31:8], 0, 8'd77); // About 30 percent stall.
    end
    drain_channel();
    repeat (4) @(negedge clk);
    if ((exp_rd == exp_wr) && (exp_wr == 5'(NumPkts))) begin
      $display("Everything OK");
    end else begin
      $display("Packets sent %0d, summaries seen %0d", exp_wr, exp_rd);
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
